// File: files.f
hdl/cache_geom_pkg.sv
hdl/cache_op_pkg.sv
hdl/lookup_access_if.sv
hdl/lru_victim_select.sv
hdl/tag_lookup.sv
hdl/line_access.sv
hdl/cache_lookup_top.sv
tests/cache_checker.sv
tests/cache_tb.sv

// File: hdl/cache_geom_pkg.sv
package cache_geom_pkg;

    // Cache shape
    localparam int NUM_WAYS  = 4;
    localparam int NUM_SETS  = 4;
    localparam int LINE_BITS = 128;

    // Physical address fields
    localparam int PADDR_BITS = 15;
    localparam int TAG_LSB    = 7;
    localparam int INDEX_LSB  = 5;

    typedef logic [PADDR_BITS-1:0] paddr_t;

    typedef logic [PADDR_BITS-TAG_LSB-1:0] tag_t;

    typedef logic [TAG_LSB-INDEX_LSB-1:0] index_t;

    typedef logic [$clog2(NUM_WAYS)-1:0] way_t;

    typedef logic [LINE_BITS-1:0] line_t;

    // One age per way, 0 is most recently used
    typedef logic [$clog2(NUM_WAYS)-1:0] age_t;

endpackage

// File: hdl/cache_lookup_top.sv
module cache_lookup_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  cache_op_pkg::op_e      req_op,
    input  cache_geom_pkg::paddr_t req_addr,
    input  cache_geom_pkg::line_t  req_data,
    input  cache_geom_pkg::line_t  req_mask,
    input  logic                   mshr_full,
    output logic                   resp_valid,
    output logic                   resp_hit,
    output cache_geom_pkg::line_t  resp_line,
    output logic                   miss,
    output cache_geom_pkg::paddr_t miss_addr,
    output logic                   wb,
    output cache_geom_pkg::paddr_t wb_addr,
    output logic                   stall
);

    // Item between the two stages
    lookup_access_if stage_if ();

    tag_lookup u_tag_lookup (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_op    (req_op),
        .req_addr  (req_addr),
        .req_data  (req_data),
        .req_mask  (req_mask),
        .mshr_full (mshr_full),
        .stall     (stall),
        .miss      (miss),
        .wb        (wb),
        .miss_addr (miss_addr),
        .wb_addr   (wb_addr),
        .out       (stage_if.lookup_mp)
    );

    line_access u_line_access (
        .clk        (clk),
        .rst_n      (rst_n),
        .in         (stage_if.access_mp),
        .resp_valid (resp_valid),
        .resp_hit   (resp_hit),
        .resp_line  (resp_line)
    );

endmodule

// File: hdl/cache_op_pkg.sv
package cache_op_pkg;

    // Request kinds seen by the lookup front end
    typedef enum logic [1:0] {
        // Load
        OP_READ  = 2'd0,
        // Store under a bit mask
        OP_WRITE = 2'd1,
        // Line returning from the bus
        OP_FILL  = 2'd2
    } op_e;

endpackage

// File: hdl/line_access.sv
module line_access (
    input  logic                  clk,
    input  logic                  rst_n,
    lookup_access_if.access_mp    in,
    output logic                  resp_valid,
    output logic                  resp_hit,
    output cache_geom_pkg::line_t resp_line
);

    cache_geom_pkg::line_t data_mem [cache_geom_pkg::NUM_SETS][cache_geom_pkg::NUM_WAYS];

    cache_geom_pkg::line_t old_line;
    cache_geom_pkg::line_t new_line;
    logic                  do_write;

    assign old_line = data_mem[in.index][in.way];
    assign do_write = in.valid && in.hit && (in.op != cache_op_pkg::OP_READ);

    // Line as it stands after this item
    always_comb begin
        case (in.op)
            cache_op_pkg::OP_WRITE: begin
                new_line = (old_line & ~in.mask) | (in.data & in.mask);
            end
            cache_op_pkg::OP_FILL: begin
                new_line = in.data;
            end
            default: begin
                new_line = old_line;
            end
        endcase
    end

    // Write lands at the same edge as the response
    always_ff @(posedge clk) begin
        if (do_write) begin
            data_mem[in.index][in.way] <= new_line;
        end
        resp_line <= new_line;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
            resp_hit   <= 1'b0;
        end else begin
            resp_valid <= in.valid;
            // Misses and dropped fills answer without data
            resp_hit   <= in.valid && in.hit;
        end
    end

endmodule

// File: hdl/lookup_access_if.sv
interface lookup_access_if;

    logic                   valid;
    cache_op_pkg::op_e      op;
    logic                   hit;
    cache_geom_pkg::index_t index;
    cache_geom_pkg::way_t   way;
    cache_geom_pkg::line_t  data;
    cache_geom_pkg::line_t  mask;

    // Stage one side
    modport lookup_mp (
        output valid,
        output op,
        output hit,
        output index,
        output way,
        output data,
        output mask
    );

    // Stage two side
    modport access_mp (
        input valid,
        input op,
        input hit,
        input index,
        input way,
        input data,
        input mask
    );

endinterface

// File: hdl/lru_victim_select.sv
module lru_victim_select (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    touch,
    input  cache_geom_pkg::index_t                  index,
    input  cache_geom_pkg::way_t                    touch_way,
    input  logic [cache_geom_pkg::NUM_WAYS-1:0]     valid_bits,
    output cache_geom_pkg::way_t                    victim
);

    cache_geom_pkg::age_t age [cache_geom_pkg::NUM_SETS][cache_geom_pkg::NUM_WAYS];
    cache_geom_pkg::age_t oldest_age;

    // Tied ages also step so that the set settles into distinct ages after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < cache_geom_pkg::NUM_SETS; s++) begin
                for (int w = 0; w < cache_geom_pkg::NUM_WAYS; w++) begin
                    age[s][w] <= '0;
                end
            end
        end else if (touch) begin
            for (int w = 0; w < cache_geom_pkg::NUM_WAYS; w++) begin
                if (w == touch_way) begin
                    age[index][w] <= '0;
                end else if (age[index][w] <= age[index][touch_way] &&
                             age[index][w] != '1) begin
                    age[index][w] <= age[index][w] + 1'b1;
                end
            end
        end
    end

    // Oldest way wins, lowest number on a tie
    always_comb begin
        oldest_age = '0;
        victim     = '0;
        for (int w = 0; w < cache_geom_pkg::NUM_WAYS; w++) begin
            if (age[index][w] > oldest_age) begin
                oldest_age = age[index][w];
                victim     = cache_geom_pkg::way_t'(w);
            end
        end
        // An empty way always goes first
        for (int w = cache_geom_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_bits[w]) begin
                victim = cache_geom_pkg::way_t'(w);
            end
        end
    end

endmodule

// File: hdl/tag_lookup.sv
module tag_lookup (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  cache_op_pkg::op_e      req_op,
    input  cache_geom_pkg::paddr_t req_addr,
    input  cache_geom_pkg::line_t  req_data,
    input  cache_geom_pkg::line_t  req_mask,
    input  logic                   mshr_full,
    output logic                   stall,
    output logic                   miss,
    output logic                   wb,
    output cache_geom_pkg::paddr_t miss_addr,
    output cache_geom_pkg::paddr_t wb_addr,
    lookup_access_if.lookup_mp     out
);

    cache_geom_pkg::tag_t tag_mem [cache_geom_pkg::NUM_SETS][cache_geom_pkg::NUM_WAYS];
    logic [cache_geom_pkg::NUM_WAYS-1:0] valid_q [cache_geom_pkg::NUM_SETS];
    logic [cache_geom_pkg::NUM_WAYS-1:0] dirty_q [cache_geom_pkg::NUM_SETS];

    cache_geom_pkg::tag_t   req_tag;
    cache_geom_pkg::index_t req_index;
    logic [cache_geom_pkg::NUM_WAYS-1:0] hit_vec;
    logic                   any_hit;
    cache_geom_pkg::way_t   hit_way;
    cache_geom_pkg::way_t   victim;
    logic                   is_access;
    logic                   accept;
    logic                   alloc;
    logic                   touch;
    logic                   victim_dirty;

    assign req_tag   = req_addr[cache_geom_pkg::PADDR_BITS-1:cache_geom_pkg::TAG_LSB];
    assign req_index = req_addr[cache_geom_pkg::TAG_LSB-1:cache_geom_pkg::INDEX_LSB];

    // Four-way tag compare
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < cache_geom_pkg::NUM_WAYS; w++) begin
            hit_vec[w] = valid_q[req_index][w] && (tag_mem[req_index][w] == req_tag);
            if (hit_vec[w]) begin
                hit_way = cache_geom_pkg::way_t'(w);
            end
        end
    end

    assign any_hit   = |hit_vec;
    assign is_access = (req_op == cache_op_pkg::OP_READ) || (req_op == cache_op_pkg::OP_WRITE);

    // Fills never wait on the miss unit
    assign stall  = req_valid && is_access && !any_hit && mshr_full;
    assign accept = req_valid && !stall;
    assign alloc  = accept && is_access && !any_hit;
    assign touch  = (accept && any_hit) || alloc;

    assign victim_dirty = valid_q[req_index][victim] && dirty_q[req_index][victim];

    lru_victim_select u_lru (
        .clk        (clk),
        .rst_n      (rst_n),
        .touch      (touch),
        .index      (req_index),
        .touch_way  (any_hit ? hit_way : victim),
        .valid_bits (valid_q[req_index]),
        .victim     (victim)
    );

    always_ff @(posedge clk) begin
        if (alloc) begin
            tag_mem[req_index][victim] <= req_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < cache_geom_pkg::NUM_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
            miss      <= 1'b0;
            wb        <= 1'b0;
            out.valid <= 1'b0;
        end else begin
            miss      <= alloc;
            wb        <= alloc && victim_dirty;
            out.valid <= accept;
            if (alloc) begin
                valid_q[req_index][victim] <= 1'b1;
                dirty_q[req_index][victim] <= 1'b0;
            end else if (accept && any_hit) begin
                if (req_op == cache_op_pkg::OP_WRITE) begin
                    dirty_q[req_index][hit_way] <= 1'b1;
                end else if (req_op == cache_op_pkg::OP_FILL) begin
                    dirty_q[req_index][hit_way] <= 1'b0;
                end
            end
        end
    end

    // Line addresses and the item for stage two
    always_ff @(posedge clk) begin
        if (alloc) begin
            miss_addr <= {req_tag, req_index, {cache_geom_pkg::INDEX_LSB{1'b0}}};
            wb_addr   <= {tag_mem[req_index][victim], req_index,
                          {cache_geom_pkg::INDEX_LSB{1'b0}}};
        end
        out.op    <= req_op;
        out.hit   <= any_hit;
        out.index <= req_index;
        out.way   <= hit_way;
        out.data  <= req_data;
        out.mask  <= req_mask;
    end

endmodule

// File: tests/cache_checker.sv
module cache_checker (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   req_valid,
    input cache_op_pkg::op_e      req_op,
    input cache_geom_pkg::paddr_t req_addr,
    input cache_geom_pkg::line_t  req_data,
    input cache_geom_pkg::line_t  req_mask,
    input logic                   mshr_full,
    input logic                   resp_valid,
    input logic                   resp_hit,
    input cache_geom_pkg::line_t  resp_line,
    input logic                   miss,
    input logic                   wb,
    input logic                   stall
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    logic                  accept;
    logic                  p1_valid;
    logic                  p2_valid;
    cache_op_pkg::op_e     p1_op;
    cache_op_pkg::op_e     p2_op;
    logic [9:0]            p1_key;
    logic [9:0]            p2_key;
    cache_geom_pkg::line_t p1_data;
    cache_geom_pkg::line_t p2_data;
    cache_geom_pkg::line_t p1_mask;
    cache_geom_pkg::line_t p2_mask;
    cache_geom_pkg::line_t exp_line;
    logic                  exp_known;

    // Shadow copy of each line address, known only after a fill
    cache_geom_pkg::line_t shadow [1024];
    logic                  known [1024];

    assign accept = req_valid && !stall;

    always_comb begin
        exp_known = known[p2_key];
        case (p2_op)
            cache_op_pkg::OP_FILL: begin
                exp_line  = p2_data;
                exp_known = 1'b1;
            end
            cache_op_pkg::OP_WRITE: begin
                exp_line = (shadow[p2_key] & ~p2_mask) | (p2_data & p2_mask);
            end
            default: begin
                exp_line = shadow[p2_key];
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            p1_valid <= 1'b0;
            p2_valid <= 1'b0;
            for (int i = 0; i < 1024; i++) begin
                known[i] <= 1'b0;
            end
        end else begin
            p1_valid <= accept;
            p1_op    <= req_op;
            p1_key   <= req_addr[14:5];
            p1_data  <= req_data;
            p1_mask  <= req_mask;
            p2_valid <= p1_valid;
            p2_op    <= p1_op;
            p2_key   <= p1_key;
            p2_data  <= p1_data;
            p2_mask  <= p1_mask;
            if (p2_valid && resp_valid && resp_hit && p2_op != cache_op_pkg::OP_READ) begin
                shadow[p2_key] <= exp_line;
                known[p2_key]  <= exp_known;
            end
        end
    end

    reset_idle: assert property (@(posedge clk)
        !rst_n |=> (!resp_valid && !resp_hit && !miss && !wb))
        else begin
            $error("outputs not idle after reset");
            fail_count++;
        end

    resp_latency: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> ##2 resp_valid)
        else begin
            $error("accepted request got no response two cycles later");
            fail_count++;
        end

    resp_source: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> $past(accept, 2))
        else begin
            $error("response without an accepted request");
            fail_count++;
        end

    stall_rule: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> (req_valid && mshr_full && req_op != cache_op_pkg::OP_FILL))
        else begin
            $error("stall raised outside its rule");
            fail_count++;
        end

    // The missing request answers without a hit
    miss_no_hit: assert property (@(posedge clk) disable iff (!rst_n)
        miss |=> (resp_valid && !resp_hit))
        else begin
            $error("missed request answered with a hit");
            fail_count++;
        end

    wb_with_miss: assert property (@(posedge clk) disable iff (!rst_n)
        wb |-> miss)
        else begin
            $error("writeback without a miss");
            fail_count++;
        end

    line_data: assert property (@(posedge clk) disable iff (!rst_n)
        (resp_valid && resp_hit && exp_known) |-> resp_line == exp_line)
        else begin
            $error("resp_line differs from shadow line");
            fail_count++;
        end

endmodule

bind cache_lookup_top cache_checker chk_i (.*);

// File: tests/cache_tb.sv
module cache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    // Reset, then the cycles of each test in order
    localparam int TEST_CYCLES = 8 + 9 + 4 + 13 + 42 + 39 + 56;
    localparam int CYCLE_LIMIT = 4 * TEST_CYCLES;

    logic                   clk;
    logic                   rst_n;
    logic                   req_valid;
    cache_op_pkg::op_e      req_op;
    cache_geom_pkg::paddr_t req_addr;
    cache_geom_pkg::line_t  req_data;
    cache_geom_pkg::line_t  req_mask;
    logic                   mshr_full;
    logic                   resp_valid;
    logic                   resp_hit;
    cache_geom_pkg::line_t  resp_line;
    logic                   miss;
    cache_geom_pkg::paddr_t miss_addr;
    logic                   wb;
    cache_geom_pkg::paddr_t wb_addr;
    logic                   stall;

    logic [31:0] lfsr = 32'd89156;
    int          cycles = 0;
    int          resp_count = 0;
    int          errors = 0;
    int          passes = 0;
    int          fails = 0;
    int          err_start;
    int          chk_start;
    string       cur_test;

    logic                   got_miss;
    logic                   got_wb;
    logic                   got_hit;
    cache_geom_pkg::paddr_t got_miss_addr;
    cache_geom_pkg::paddr_t got_wb_addr;
    cache_geom_pkg::line_t  got_line;

    cache_lookup_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (resp_valid) begin
            resp_count++;
        end
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic next_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic cache_geom_pkg::line_t rand_line();
        cache_geom_pkg::line_t v;
        for (int i = 0; i < 128; i++) begin
            v[i] = next_bit();
        end
        return v;
    endfunction

    function automatic cache_geom_pkg::paddr_t line_addr(logic [7:0] tag, logic [1:0] idx);
        return {tag, idx, 5'b0};
    endfunction

    task automatic check(input string what, input logic [127:0] exp, input logic [127:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        err_start = errors;
        chk_start = dut_i.chk_i.fail_count;
    endtask

    task automatic end_test();
        if (errors == err_start && dut_i.chk_i.fail_count == chk_start) begin
            passes++;
            $display("test %s: pass", cur_test);
        end else begin
            fails++;
            $display("test %s: fail", cur_test);
        end
    endtask

    task automatic issue(input cache_op_pkg::op_e op, input cache_geom_pkg::paddr_t addr,
                         input cache_geom_pkg::line_t data, input cache_geom_pkg::line_t mask);
        @(negedge clk);
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_data  = data;
        req_mask  = mask;
    endtask

    // One request, waits out any stall, samples miss and response
    task automatic access(input cache_op_pkg::op_e op, input cache_geom_pkg::paddr_t addr,
                          input cache_geom_pkg::line_t data, input cache_geom_pkg::line_t mask);
        issue(op, addr, data, mask);
        #1;
        while (stall) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        req_valid     = 1'b0;
        got_miss      = miss;
        got_wb        = wb;
        got_miss_addr = miss_addr;
        got_wb_addr   = wb_addr;
        @(negedge clk);
        got_hit  = resp_hit;
        got_line = resp_line;
    endtask

    initial begin
        cache_geom_pkg::line_t      d1;
        cache_geom_pkg::line_t      d2;
        cache_geom_pkg::line_t      wd;
        cache_geom_pkg::line_t      m;
        cache_geom_pkg::paddr_t     keys [4];
        int                         cnt0;
        int                         chk;

        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_op    = cache_op_pkg::OP_READ;
        req_addr  = '0;
        req_data  = '0;
        req_mask  = '0;
        mshr_full = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        start_test("cold_miss_fill");
        d1 = rand_line();
        access(cache_op_pkg::OP_READ, line_addr(8'h11, 2'd0), '0, '0);
        check("miss", 1'b1, got_miss);
        check("miss_addr", line_addr(8'h11, 2'd0), got_miss_addr);
        check("resp_hit", 1'b0, got_hit);
        access(cache_op_pkg::OP_FILL, line_addr(8'h11, 2'd0), d1, '0);
        check("fill hit", 1'b1, got_hit);
        access(cache_op_pkg::OP_READ, line_addr(8'h11, 2'd0), '0, '0);
        check("read hit", 1'b1, got_hit);
        check("read line", d1, got_line);
        end_test();

        start_test("masked_write");
        wd = rand_line();
        m  = rand_line();
        issue(cache_op_pkg::OP_WRITE, line_addr(8'h11, 2'd0), wd, m);
        issue(cache_op_pkg::OP_READ, line_addr(8'h11, 2'd0), '0, '0);
        @(negedge clk);
        req_valid = 1'b0;
        @(negedge clk);
        check("read hit", 1'b1, resp_hit);
        check("merged line", (d1 & ~m) | (wd & m), resp_line);
        end_test();

        start_test("stall");
        mshr_full = 1'b1;
        issue(cache_op_pkg::OP_READ, line_addr(8'h22, 2'd1), '0, '0);
        repeat (4) begin
            @(negedge clk);
            if (!stall || miss || resp_valid) begin
                $display("stall test: missing read was not held while the miss unit was full");
                errors++;
            end
        end
        mshr_full = 1'b0;
        @(negedge clk);
        req_valid = 1'b0;
        check("miss", 1'b1, miss);
        check("miss_addr", line_addr(8'h22, 2'd1), miss_addr);
        @(negedge clk);
        d2 = rand_line();
        access(cache_op_pkg::OP_FILL, line_addr(8'h22, 2'd1), d2, '0);
        mshr_full = 1'b1;
        access(cache_op_pkg::OP_READ, line_addr(8'h22, 2'd1), '0, '0);
        check("hit under full", 1'b1, got_hit);
        check("line", d2, got_line);
        mshr_full = 1'b0;
        end_test();

        start_test("lru_evict");
        for (int i = 0; i < 4; i++) begin
            access(cache_op_pkg::OP_READ, line_addr(8'(8'h30 + i), 2'd2), '0, '0);
            access(cache_op_pkg::OP_FILL, line_addr(8'(8'h30 + i), 2'd2), rand_line(), '0);
        end
        for (int i = 1; i < 4; i++) begin
            access(cache_op_pkg::OP_READ, line_addr(8'(8'h30 + i), 2'd2), '0, '0);
            check("touch hit", 1'b1, got_hit);
        end
        access(cache_op_pkg::OP_READ, line_addr(8'h34, 2'd2), '0, '0);
        check("miss_addr", line_addr(8'h34, 2'd2), got_miss_addr);
        check("clean wb", 1'b0, got_wb);
        access(cache_op_pkg::OP_READ, line_addr(8'h30, 2'd2), '0, '0);
        check("evicted miss", 1'b1, got_miss);
        access(cache_op_pkg::OP_READ, line_addr(8'h32, 2'd2), '0, '0);
        check("touched hit", 1'b1, got_hit);
        end_test();

        start_test("dirty_wb");
        for (int i = 0; i < 4; i++) begin
            access(cache_op_pkg::OP_READ, line_addr(8'(8'h50 + i), 2'd3), '0, '0);
            access(cache_op_pkg::OP_FILL, line_addr(8'(8'h50 + i), 2'd3), rand_line(), '0);
        end
        access(cache_op_pkg::OP_WRITE, line_addr(8'h50, 2'd3), rand_line(), rand_line());
        for (int i = 0; i < 3; i++) begin
            access(cache_op_pkg::OP_READ, line_addr(8'(8'h60 + i), 2'd3), '0, '0);
            check("miss", 1'b1, got_miss);
            check("clean wb", 1'b0, got_wb);
        end
        access(cache_op_pkg::OP_READ, line_addr(8'h63, 2'd3), '0, '0);
        check("dirty wb", 1'b1, got_wb);
        check("wb_addr", line_addr(8'h50, 2'd3), got_wb_addr);
        end_test();

        start_test("pipelined");
        keys[0] = line_addr(8'h11, 2'd0);
        keys[1] = line_addr(8'h22, 2'd1);
        keys[2] = line_addr(8'h33, 2'd2);
        keys[3] = line_addr(8'h63, 2'd3);
        for (int i = 0; i < 4; i++) begin
            access(cache_op_pkg::OP_FILL, keys[i], rand_line(), '0);
        end
        // Last fill response is counted at the next edge
        @(negedge clk);
        cnt0 = resp_count;
        for (int i = 0; i < 40; i++) begin
            issue(next_bit() ? cache_op_pkg::OP_WRITE : cache_op_pkg::OP_READ,
                  keys[{next_bit(), next_bit()}], rand_line(), rand_line());
        end
        @(negedge clk);
        req_valid = 1'b0;
        repeat (2) @(negedge clk);
        check("responses", 40, resp_count - cnt0);
        end_test();

        chk = dut_i.chk_i.fail_count;
        $display("passed %0d, failed %0d, checker failures %0d", passes, fails, chk);
        if (fails == 0 && errors == 0 && chk == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
